// File: logic/simMemPkg.sv
package simMemPkg;

    // Bus and memory geometry.
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int ID_WIDTH   = 4;
    localparam int NUM_BANKS  = 4;
    localparam int BANK_DEPTH = 256;

    typedef logic [ADDR_WIDTH-1:0] addrT;
    typedef logic [DATA_WIDTH-1:0] dataT;
    typedef logic [DATA_WIDTH/8-1:0] strbT;
    typedef logic [ID_WIDTH-1:0] idT;
    typedef logic [7:0] lenT;

    // Two low bits of the word index.
    typedef logic [$clog2(NUM_BANKS)-1:0] bankSelT;

    // Word index bits above the bank select.
    typedef logic [$clog2(BANK_DEPTH)-1:0] rowT;

    typedef enum logic [1:0] {
        IDLE,
        READING,
        WRITING,
        RESPONSE
    } engineStateT;

endpackage

// File: logic/memBank.sv
`timescale 1ns/10ps

module memBank (
    input  logic              clk,
    input  logic              re,
    input  logic              we,
    input  simMemPkg::rowT    row,
    input  simMemPkg::dataT   wdata,
    input  simMemPkg::strbT   wstrb,
    output simMemPkg::dataT   rdata
);

    simMemPkg::dataT mem [simMemPkg::BANK_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < simMemPkg::DATA_WIDTH / 8; b++) begin
                if (wstrb[b]) begin
                    mem[row][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
        // Read data is ready the cycle after re.
        if (re) begin
            rdata <= mem[row];
        end
    end

endmodule

// File: logic/burstEngine.sv
`timescale 1ns/10ps

module burstEngine (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                arValid,
    output logic                                arReady,
    input  simMemPkg::idT                       arId,
    input  simMemPkg::addrT                     arAddr,
    input  simMemPkg::lenT                      arLen,
    input  logic [2:0]                          arSize,
    input  logic [1:0]                          arBurst,

    input  logic                                awValid,
    output logic                                awReady,
    input  simMemPkg::idT                       awId,
    input  simMemPkg::addrT                     awAddr,
    input  simMemPkg::lenT                      awLen,
    input  logic [2:0]                          awSize,
    input  logic [1:0]                          awBurst,

    input  logic                                wValid,
    output logic                                wReady,
    input  simMemPkg::dataT                     wData,
    input  simMemPkg::strbT                     wStrb,
    input  logic                                wLast,

    output logic [simMemPkg::NUM_BANKS-1:0]     bankRe,
    output logic [simMemPkg::NUM_BANKS-1:0]     bankWe,
    output simMemPkg::rowT                      bankRow,
    output simMemPkg::dataT                     bankWdata,
    output simMemPkg::strbT                     bankWstrb,

    output logic                                beatIssue,
    output simMemPkg::bankSelT                  beatBank,
    output logic [1:0]                          beatOffset,
    output logic                                beatLast,
    output simMemPkg::idT                       beatId,

    output logic                                writeDone,
    output simMemPkg::idT                       doneId,

    input  logic                                issueReady,
    input  logic                                respIdle
);

    simMemPkg::engineStateT state;
    logic [8:0]             beatsLeft;
    logic [2:0]             sizeBytes;
    logic                   burstFixed;
    simMemPkg::idT          burstId;
    simMemPkg::addrT        curAddr;
    simMemPkg::addrT        nextAddr;

    logic                   takeRead;
    logic                   startFire;
    logic                   startFixed;
    logic [2:0]             startSize;
    logic [2:0]             startBytes;
    logic [1:0]             startMask;
    simMemPkg::addrT        startAddr;
    simMemPkg::addrT        startAligned;

    logic                   wFire;
    simMemPkg::strbT        sizeStrb;
    logic [simMemPkg::NUM_BANKS-1:0] bankOneHot;

    function automatic logic [2:0] sizeToBytes(input logic [2:0] size);
        case (size)
            3'd0:    return 3'd1;
            3'd1:    return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

    // A read wins when both address channels are valid.
    assign takeRead   = arValid;
    assign startFire  = (state == simMemPkg::IDLE) && (arValid || awValid);
    assign startAddr  = takeRead ? arAddr : awAddr;
    assign startSize  = takeRead ? arSize : awSize;
    assign startFixed = takeRead ? (arBurst == 2'b00) : (awBurst == 2'b00);
    assign startBytes = sizeToBytes(startSize);

    // Align the start address down to the beat size.
    assign startMask    = ~(startBytes[1:0] - 2'd1);
    assign startAligned = {startAddr[simMemPkg::ADDR_WIDTH-1:2], startAddr[1:0] & startMask};

    assign nextAddr = burstFixed ? curAddr : curAddr + sizeBytes;

    assign arReady = (state == simMemPkg::IDLE);
    assign awReady = (state == simMemPkg::IDLE) && !arValid;
    assign wReady  = (state == simMemPkg::WRITING);
    assign wFire   = wValid && wReady;

    assign beatBank   = curAddr[3:2];
    assign beatOffset = curAddr[1:0];
    assign beatLast   = (beatsLeft == 9'd1);
    assign beatId     = burstId;
    assign beatIssue  = (state == simMemPkg::READING) && issueReady;

    assign bankOneHot = {{(simMemPkg::NUM_BANKS-1){1'b0}}, 1'b1} << beatBank;
    assign bankRe     = beatIssue ? bankOneHot : '0;
    assign bankWe     = wFire ? bankOneHot : '0;
    assign bankRow    = curAddr[11:4];

    // Narrow write data arrives in the low lanes.
    assign sizeStrb  = simMemPkg::strbT'((5'd1 << sizeBytes) - 5'd1);
    assign bankWdata = wData << {beatOffset, 3'b000};
    assign bankWstrb = (wStrb & sizeStrb) << beatOffset;

    assign writeDone = wFire && wLast;
    assign doneId    = burstId;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= simMemPkg::IDLE;
            beatsLeft <= '0;
        end else begin
            case (state)
                simMemPkg::IDLE: begin
                    if (arValid) begin
                        state     <= simMemPkg::READING;
                        beatsLeft <= startFixed ? 9'd1 : {1'b0, arLen} + 9'd1;
                    end else if (awValid) begin
                        state     <= simMemPkg::WRITING;
                        beatsLeft <= startFixed ? 9'd1 : {1'b0, awLen} + 9'd1;
                    end
                end
                simMemPkg::READING: begin
                    if (beatIssue) begin
                        beatsLeft <= beatsLeft - 9'd1;
                        if (beatLast) begin
                            state <= simMemPkg::RESPONSE;
                        end
                    end
                end
                simMemPkg::WRITING: begin
                    // The master's wLast closes the burst.
                    if (writeDone) begin
                        state <= simMemPkg::RESPONSE;
                    end
                end
                simMemPkg::RESPONSE: begin
                    if (respIdle) begin
                        state <= simMemPkg::IDLE;
                    end
                end
                default: state <= simMemPkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (startFire) begin
            burstId    <= takeRead ? arId : awId;
            curAddr    <= startAligned;
            sizeBytes  <= startBytes;
            burstFixed <= startFixed;
        end else if (beatIssue || wFire) begin
            curAddr <= nextAddr;
        end
    end

endmodule

// File: logic/respCollector.sv
`timescale 1ns/10ps

module respCollector (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            beatIssue,
    input  simMemPkg::bankSelT                              beatBank,
    input  logic [1:0]                                      beatOffset,
    input  logic                                            beatLast,
    input  simMemPkg::idT                                   beatId,
    input  simMemPkg::dataT [simMemPkg::NUM_BANKS-1:0]      bankRdata,
    input  logic                                            writeDone,
    input  simMemPkg::idT                                   doneId,
    input  logic                                            rReady,
    input  logic                                            bReady,
    output logic                                            issueReady,
    output logic                                            respIdle,
    output logic                                            rValid,
    output simMemPkg::idT                                   rId,
    output simMemPkg::dataT                                 rData,
    output logic [1:0]                                      rResp,
    output logic                                            rLast,
    output logic                                            bValid,
    output simMemPkg::idT                                   bId,
    output logic [1:0]                                      bResp
);

    logic               tagValid;
    simMemPkg::bankSelT tagBank;
    logic [1:0]         tagOffset;
    logic               tagLast;
    simMemPkg::idT      tagId;
    simMemPkg::dataT    alignedWord;

    simMemPkg::dataT    bufData [2];
    simMemPkg::idT      bufId [2];
    logic               bufLast [2];
    logic               wrPtr;
    logic               rdPtr;
    logic [1:0]         count;
    logic               pop;
    logic [2:0]         occupancy;

    // The tag meets its bank's word one cycle after issue.
    assign alignedWord = bankRdata[tagBank] >> {tagOffset, 3'b000};

    assign pop = rValid && rReady;

    // Buffered words plus the one in flight, less the one leaving now.
    assign occupancy  = {1'b0, count} + {2'b00, tagValid} - {2'b00, pop};
    assign issueReady = (occupancy < 3'd2);

    // Nothing pending on B and the last R beat gone or leaving.
    assign respIdle = (!bValid || bReady) && !tagValid
                      && ((count == 2'd0) || ((count == 2'd1) && pop));

    assign rValid = (count != 2'd0);
    assign rData  = bufData[rdPtr];
    assign rId    = bufId[rdPtr];
    assign rLast  = bufLast[rdPtr];
    assign rResp  = 2'b00;
    assign bResp  = 2'b00;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tagValid <= 1'b0;
            wrPtr    <= 1'b0;
            rdPtr    <= 1'b0;
            count    <= 2'd0;
            bValid   <= 1'b0;
        end else begin
            tagValid <= beatIssue;
            if (tagValid) begin
                wrPtr <= ~wrPtr;
            end
            if (pop) begin
                rdPtr <= ~rdPtr;
            end
            case ({tagValid, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
            if (writeDone) begin
                bValid <= 1'b1;
            end else if (bValid && bReady) begin
                bValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        tagBank   <= beatBank;
        tagOffset <= beatOffset;
        tagLast   <= beatLast;
        tagId     <= beatId;
        if (tagValid) begin
            bufData[wrPtr] <= alignedWord;
            bufId[wrPtr]   <= tagId;
            bufLast[wrPtr] <= tagLast;
        end
        if (writeDone) begin
            bId <= doneId;
        end
    end

endmodule

// File: logic/simMemory.sv
`timescale 1ns/10ps

module simMemory (
    input  logic                clk,
    input  logic                rst,

    input  logic                arValid,
    output logic                arReady,
    input  simMemPkg::idT       arId,
    input  simMemPkg::addrT     arAddr,
    input  simMemPkg::lenT      arLen,
    input  logic [2:0]          arSize,
    input  logic [1:0]          arBurst,

    output logic                rValid,
    input  logic                rReady,
    output simMemPkg::idT       rId,
    output simMemPkg::dataT     rData,
    output logic [1:0]          rResp,
    output logic                rLast,

    input  logic                awValid,
    output logic                awReady,
    input  simMemPkg::idT       awId,
    input  simMemPkg::addrT     awAddr,
    input  simMemPkg::lenT      awLen,
    input  logic [2:0]          awSize,
    input  logic [1:0]          awBurst,

    input  logic                wValid,
    output logic                wReady,
    input  simMemPkg::dataT     wData,
    input  simMemPkg::strbT     wStrb,
    input  logic                wLast,

    output logic                bValid,
    input  logic                bReady,
    output simMemPkg::idT       bId,
    output logic [1:0]          bResp
);

    logic [simMemPkg::NUM_BANKS-1:0]                bankRe;
    logic [simMemPkg::NUM_BANKS-1:0]                bankWe;
    simMemPkg::rowT                                 bankRow;
    simMemPkg::dataT                                bankWdata;
    simMemPkg::strbT                                bankWstrb;
    simMemPkg::dataT [simMemPkg::NUM_BANKS-1:0]     bankRdata;

    logic                   beatIssue;
    simMemPkg::bankSelT     beatBank;
    logic [1:0]             beatOffset;
    logic                   beatLast;
    simMemPkg::idT          beatId;
    logic                   issueReady;
    logic                   writeDone;
    simMemPkg::idT          doneId;
    logic                   respIdle;

    burstEngine engine (
        .clk        (clk),
        .rst        (rst),
        .arValid    (arValid),
        .arReady    (arReady),
        .arId       (arId),
        .arAddr     (arAddr),
        .arLen      (arLen),
        .arSize     (arSize),
        .arBurst    (arBurst),
        .awValid    (awValid),
        .awReady    (awReady),
        .awId       (awId),
        .awAddr     (awAddr),
        .awLen      (awLen),
        .awSize     (awSize),
        .awBurst    (awBurst),
        .wValid     (wValid),
        .wReady     (wReady),
        .wData      (wData),
        .wStrb      (wStrb),
        .wLast      (wLast),
        .bankRe     (bankRe),
        .bankWe     (bankWe),
        .bankRow    (bankRow),
        .bankWdata  (bankWdata),
        .bankWstrb  (bankWstrb),
        .beatIssue  (beatIssue),
        .beatBank   (beatBank),
        .beatOffset (beatOffset),
        .beatLast   (beatLast),
        .beatId     (beatId),
        .writeDone  (writeDone),
        .doneId     (doneId),
        .issueReady (issueReady),
        .respIdle   (respIdle)
    );

    // Word-interleaved banks.
    for (genvar g = 0; g < simMemPkg::NUM_BANKS; g++) begin : genBank
        memBank bank (
            .clk   (clk),
            .re    (bankRe[g]),
            .we    (bankWe[g]),
            .row   (bankRow),
            .wdata (bankWdata),
            .wstrb (bankWstrb),
            .rdata (bankRdata[g])
        );
    end

    respCollector collector (
        .clk        (clk),
        .rst        (rst),
        .beatIssue  (beatIssue),
        .beatBank   (beatBank),
        .beatOffset (beatOffset),
        .beatLast   (beatLast),
        .beatId     (beatId),
        .bankRdata  (bankRdata),
        .writeDone  (writeDone),
        .doneId     (doneId),
        .rReady     (rReady),
        .bReady     (bReady),
        .issueReady (issueReady),
        .respIdle   (respIdle),
        .rValid     (rValid),
        .rId        (rId),
        .rData      (rData),
        .rResp      (rResp),
        .rLast      (rLast),
        .bValid     (bValid),
        .bId        (bId),
        .bResp      (bResp)
    );

endmodule

// File: bench/clockGen.sv
`timescale 1ns/10ps

module clockGen (
    output logic clk,
    output logic rst
);

    // 40 ns period.
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

// File: bench/simMemoryChecker.sv
`timescale 1ns/10ps

module simMemoryChecker (
    input  logic                clk,
    input  logic                rst,
    input  logic                arValid,
    input  logic                arReady,
    input  simMemPkg::idT       arId,
    input  simMemPkg::addrT     arAddr,
    input  simMemPkg::lenT      arLen,
    input  logic [2:0]          arSize,
    input  logic [1:0]          arBurst,
    input  logic                rValid,
    input  logic                rReady,
    input  simMemPkg::idT       rId,
    input  simMemPkg::dataT     rData,
    input  logic [1:0]          rResp,
    input  logic                rLast,
    input  logic                awValid,
    input  logic                awReady,
    input  simMemPkg::idT       awId,
    input  simMemPkg::addrT     awAddr,
    input  simMemPkg::lenT      awLen,
    input  logic [2:0]          awSize,
    input  logic [1:0]          awBurst,
    input  logic                wValid,
    input  logic                wReady,
    input  simMemPkg::dataT     wData,
    input  simMemPkg::strbT     wStrb,
    input  logic                wLast,
    input  logic                bValid,
    input  logic                bReady,
    input  simMemPkg::idT       bId,
    input  logic [1:0]          bResp
);

    // Byte image of the 4 KB memory.
    logic [7:0]     model [4096];

    logic [11:0]    wrAddr;
    int             wrBytes = 0;
    logic           wrFixed;
    simMemPkg::idT  wrId;
    logic           wrPending = 1'b0;
    int             wrLeft = 0;

    logic [11:0]    rdAddr;
    int             rdBytes = 0;
    logic           rdFixed;
    simMemPkg::idT  rdIdExp;
    int             rdLeft = 0;

    string          testName = "none";
    int             testErrors = 0;
    int             testsRun = 0;
    int             testsFailed = 0;
    int             errorTotal = 0;

    task automatic noteError();
        testErrors++;
        errorTotal++;
    endtask

    task automatic checkValue(input string field, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s %s: expected %h, actual %h", testName, field, expected, actual);
            noteError();
        end
    endtask

    task automatic beginTest(input string name);
        testName = name;
        testErrors = 0;
    endtask

    task automatic endTest();
        if (rdLeft != 0) begin
            $display("Test %s ended with %0d read beats never returned", testName, rdLeft);
            noteError();
        end
        if (wrPending) begin
            $display("Test %s ended with a write response never returned", testName);
            noteError();
        end
        testsRun++;
        if (testErrors == 0) begin
            $display("Pass %s", testName);
        end else begin
            testsFailed++;
            $display("Test %s failed with %0d errors", testName, testErrors);
        end
    endtask

    task automatic printSummary();
        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 testsRun, testsFailed, errorTotal);
    endtask

    always @(posedge clk) begin : watch
        logic [31:0] expData;
        logic [31:0] mask;
        if (!rst) begin
            // Start addresses align down to the beat size; bits above 4 KB wrap.
            if (awValid && awReady) begin
                wrBytes = 1 << awSize;
                wrAddr  = awAddr[11:0] & ~12'(wrBytes - 1);
                wrFixed = (awBurst == 2'b00);
                wrId    = awId;
                wrLeft  = wrFixed ? 1 : int'(awLen) + 1;
            end
            // W closes after the burst's final beat.
            if (wReady && wrLeft == 0) begin
                $display("Test %s saw wReady high with no write beat outstanding", testName);
                noteError();
            end
            if (wValid && wReady) begin
                for (int i = 0; i < wrBytes; i++) begin
                    if (wStrb[i]) begin
                        model[wrAddr + 12'(i)] = wData[8*i +: 8];
                    end
                end
                if (!wrFixed) begin
                    wrAddr = wrAddr + 12'(wrBytes);
                end
                if (wrLeft > 0) begin
                    wrLeft--;
                end
                if (wLast) begin
                    wrPending = 1'b1;
                end
            end
            if (bValid && bReady) begin
                if (!wrPending) begin
                    $display("Test %s got a B response with no write burst finished", testName);
                    noteError();
                end
                checkValue("bId", 32'(wrId), 32'(bId));
                checkValue("bResp", 32'd0, 32'(bResp));
                wrPending = 1'b0;
            end
            if (arValid && arReady) begin
                rdBytes = 1 << arSize;
                rdAddr  = arAddr[11:0] & ~12'(rdBytes - 1);
                rdFixed = (arBurst == 2'b00);
                rdIdExp = arId;
                rdLeft  = rdFixed ? 1 : int'(arLen) + 1;
            end
            if (rValid && rReady) begin
                if (rdLeft == 0) begin
                    $display("Test %s got an R beat with no read beat outstanding", testName);
                    noteError();
                end else begin
                    expData = '0;
                    mask    = '0;
                    for (int i = 0; i < rdBytes; i++) begin
                        expData[8*i +: 8] = model[rdAddr + 12'(i)];
                        mask[8*i +: 8]    = 8'hFF;
                    end
                    checkValue("rData", expData, rData & mask);
                    checkValue("rId", 32'(rdIdExp), 32'(rId));
                    checkValue("rResp", 32'd0, 32'(rResp));
                    checkValue("rLast", 32'(rdLeft == 1), 32'(rLast));
                    rdLeft--;
                    if (!rdFixed) begin
                        rdAddr = rdAddr + 12'(rdBytes);
                    end
                end
            end
        end
    end

endmodule

// File: bench/simMemory_props.sv
`timescale 1ns/10ps

module simMemoryProps (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            arValid,
    input  logic                            arReady,
    input  logic                            awValid,
    input  logic                            awReady,
    input  logic                            rValid,
    input  logic                            rReady,
    input  logic                            rLast,
    input  simMemPkg::dataT                 rData,
    input  simMemPkg::idT                   rId,
    input  logic                            bValid,
    input  logic                            bReady,
    input  simMemPkg::idT                   bId,
    input  logic [simMemPkg::NUM_BANKS-1:0] bankWe,
    input  logic [simMemPkg::NUM_BANKS-1:0] bankRe
);

    // High from the address transfer to the rLast or B transfer.
    logic busy;

    int failCount = 0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
        end else if ((arValid && arReady) || (awValid && awReady)) begin
            busy <= 1'b1;
        end else if ((rValid && rReady && rLast) || (bValid && bReady)) begin
            busy <= 1'b0;
        end
    end

    rHold: assert property (@(posedge clk) disable iff (rst)
        rValid && !rReady |=> rValid && $stable(rData) && $stable(rId) && $stable(rLast))
        else begin
            failCount++;
            $error("R channel changed before its transfer");
        end

    bHold: assert property (@(posedge clk) disable iff (rst)
        bValid && !bReady |=> bValid && $stable(bId))
        else begin
            failCount++;
            $error("B channel changed before its transfer");
        end

    arBlocked: assert property (@(posedge clk) disable iff (rst)
        busy |-> !arReady)
        else begin
            failCount++;
            $error("arReady high during an active burst");
        end

    oneBank: assert property (@(posedge clk) disable iff (rst)
        $onehot0(bankWe | bankRe))
        else begin
            failCount++;
            $error("More than one bank enabled in a cycle");
        end

endmodule

bind simMemory simMemoryProps props (.*);

// File: bench/simMemoryTb.sv
`timescale 1ns/10ps

module simMemoryTb;

    localparam int          WAIT_LIMIT = 2000;
    localparam int          RUN_LIMIT  = 200000;
    localparam logic [1:0]  FIXED      = 2'b00;
    localparam logic [1:0]  INCR       = 2'b01;

    logic                clk;
    logic                rst;
    logic                arValid;
    logic                arReady;
    simMemPkg::idT       arId;
    simMemPkg::addrT     arAddr;
    simMemPkg::lenT      arLen;
    logic [2:0]          arSize;
    logic [1:0]          arBurst;
    logic                rValid;
    logic                rReady;
    simMemPkg::idT       rId;
    simMemPkg::dataT     rData;
    logic [1:0]          rResp;
    logic                rLast;
    logic                awValid;
    logic                awReady;
    simMemPkg::idT       awId;
    simMemPkg::addrT     awAddr;
    simMemPkg::lenT      awLen;
    logic [2:0]          awSize;
    logic [1:0]          awBurst;
    logic                wValid;
    logic                wReady;
    simMemPkg::dataT     wData;
    simMemPkg::strbT     wStrb;
    logic                wLast;
    logic                bValid;
    logic                bReady;
    simMemPkg::idT       bId;
    logic [1:0]          bResp;

    logic                aborted = 1'b0;
    logic                runDone = 1'b0;
    logic                stallMode = 1'b0;

    clockGen clocks (
        .clk (clk),
        .rst (rst)
    );

    simMemory dut (.*);

    simMemoryChecker chk (.*);

    task automatic parkOnTimeout(input string what);
        $display("Timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
        aborted = 1'b1;
        // The finisher ends the run.
        forever @(posedge clk);
    endtask

    function automatic simMemPkg::addrT randomAddr(input logic [2:0] size);
        simMemPkg::addrT a;
        a = {20'h00000, 12'($urandom)};
        return a & ~((32'd1 << size) - 32'd1);
    endfunction

    function automatic simMemPkg::idT randomId();
        return simMemPkg::idT'($urandom);
    endfunction

    task automatic waitForReset();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) parkOnTimeout("reset release");
        end while (rst);
        #1;
    endtask

    task automatic writeBurst(input simMemPkg::idT id, input simMemPkg::addrT addr,
                              input simMemPkg::lenT len, input logic [2:0] size,
                              input logic randomStrb);
        int   cycles;
        logic done;
        awId    = id;
        awAddr  = addr;
        awLen   = len;
        awSize  = size;
        awBurst = INCR;
        awValid = 1'b1;
        cycles  = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) parkOnTimeout("AW handshake");
        end while (!awReady);
        #1;
        awValid = 1'b0;
        for (int beat = 0; beat <= int'(len); beat++) begin
            wData  = $urandom;
            wStrb  = randomStrb ? simMemPkg::strbT'($urandom) : 4'hF;
            wLast  = (beat == int'(len));
            wValid = 1'b1;
            cycles = 0;
            do begin
                @(posedge clk);
                cycles++;
                if (cycles > WAIT_LIMIT) parkOnTimeout("W handshake");
            end while (!wReady);
            #1;
        end
        wValid = 1'b0;
        wLast  = 1'b0;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            bReady = stallMode ? (($urandom % 3) != 0) : 1'b1;
            @(posedge clk);
            done = bValid && bReady;
            cycles++;
            if (!done && cycles > WAIT_LIMIT) parkOnTimeout("B handshake");
            #1;
        end
        bReady = 1'b0;
    endtask

    task automatic readBurst(input simMemPkg::idT id, input simMemPkg::addrT addr,
                             input simMemPkg::lenT len, input logic [2:0] size,
                             input logic [1:0] burst);
        int   cycles;
        logic done;
        arId    = id;
        arAddr  = addr;
        arLen   = len;
        arSize  = size;
        arBurst = burst;
        arValid = 1'b1;
        cycles  = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) parkOnTimeout("AR handshake");
        end while (!arReady);
        #1;
        arValid = 1'b0;
        cycles  = 0;
        done    = 1'b0;
        while (!done) begin
            rReady = stallMode ? (($urandom % 3) != 0) : 1'b1;
            @(posedge clk);
            done = rValid && rReady && rLast;
            cycles++;
            if (!done && cycles > WAIT_LIMIT) parkOnTimeout("R transfer with rLast");
            #1;
        end
        rReady = 1'b0;
    endtask

    initial begin : stimulus
        simMemPkg::addrT addr;
        simMemPkg::lenT  len;
        logic [2:0]      size;

        void'($urandom(32'h39df));
        arValid = 1'b0;
        arId    = '0;
        arAddr  = '0;
        arLen   = '0;
        arSize  = 3'd2;
        arBurst = INCR;
        rReady  = 1'b0;
        awValid = 1'b0;
        awId    = '0;
        awAddr  = '0;
        awLen   = '0;
        awSize  = 3'd2;
        awBurst = INCR;
        wValid  = 1'b0;
        wData   = '0;
        wStrb   = '0;
        wLast   = 1'b0;
        bReady  = 1'b0;
        waitForReset();

        // Four 256-beat bursts cover all 4 KB.
        chk.beginTest("fill");
        for (int k = 0; k < 4; k++) begin
            writeBurst(randomId(), simMemPkg::addrT'(k * 1024), 8'd255, 3'd2, 1'b0);
        end
        chk.endTest();

        chk.beginTest("singleWord");
        repeat (8) begin
            addr = randomAddr(3'd2);
            writeBurst(randomId(), addr, 8'd0, 3'd2, 1'b0);
            readBurst(randomId(), addr, 8'd0, 3'd2, INCR);
        end
        chk.endTest();

        chk.beginTest("incrBurst");
        repeat (6) begin
            addr = randomAddr(3'd2);
            len  = simMemPkg::lenT'(3 + $urandom % 13);
            writeBurst(randomId(), addr, len, 3'd2, 1'b0);
            readBurst(randomId(), addr, len, 3'd2, INCR);
        end
        chk.endTest();

        // Word read-back also shows the bytes that must not change.
        chk.beginTest("narrowStrobe");
        repeat (12) begin
            size = 3'($urandom % 2);
            addr = randomAddr(size);
            len  = simMemPkg::lenT'($urandom % 8);
            writeBurst(randomId(), addr, len, size, 1'b1);
            readBurst(randomId(), addr, len, size, INCR);
            readBurst(randomId(), addr & ~32'd3, len, 3'd2, INCR);
        end
        chk.endTest();

        chk.beginTest("fixedBurst");
        repeat (4) begin
            len = simMemPkg::lenT'(1 + $urandom % 15);
            readBurst(randomId(), randomAddr(3'd2), len, 3'd2, FIXED);
        end
        chk.endTest();

        chk.beginTest("stalls");
        stallMode = 1'b1;
        repeat (6) begin
            addr = randomAddr(3'd2);
            len  = simMemPkg::lenT'($urandom % 16);
            writeBurst(randomId(), addr, len, 3'd2, 1'b1);
            readBurst(randomId(), addr, len, 3'd2, INCR);
        end
        stallMode = 1'b0;
        chk.endTest();

        // Writes go above 4 KB, reads come from the low alias.
        chk.beginTest("aliasHigh");
        repeat (4) begin
            addr = randomAddr(3'd2);
            len  = simMemPkg::lenT'($urandom % 4);
            writeBurst(randomId(), addr | {19'($urandom), 1'b1, 12'h000}, len, 3'd2, 1'b0);
            readBurst(randomId(), addr, len, 3'd2, INCR);
        end
        chk.endTest();

        runDone = 1'b1;
    end

    initial begin : finisher
        int cycles;
        cycles = 0;
        while (!runDone && !aborted) begin
            @(posedge clk);
            cycles++;
            if (cycles > RUN_LIMIT) begin
                $display("Timeout: the test sequence did not finish within %0d cycles",
                         RUN_LIMIT);
                aborted = 1'b1;
            end
        end
        chk.printSummary();
        if (!aborted && chk.errorTotal == 0 && dut.props.failCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: simMemory.f
logic/simMemPkg.sv
logic/memBank.sv
logic/burstEngine.sv
logic/respCollector.sv
logic/simMemory.sv
bench/clockGen.sv
bench/simMemoryChecker.sv
bench/simMemory_props.sv
bench/simMemoryTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Builds the simMemory testbench with Verilator and runs it.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module simMemoryTb \
    -f simMemory.f \
    -o VsimMemoryTb

./obj_dir/VsimMemoryTb | tee sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "Simulation reported failure."
    exit 1
fi
echo "Simulation finished without failure."
